// File: common/mmu_defines.svh
// Sv39 data MMU constants
// address widths, PTE bit positions, cause and privilege codes, TLB depth
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

// ----------------------------------------------------------------------
// address and data widths
// ----------------------------------------------------------------------
`define MMU_VLEN       39
`define MMU_PLEN       56
`define MMU_XLEN       64
`define MMU_PPN_W      44
// one VPN field, three of them in Sv39
`define MMU_VPN_W      9
`define MMU_PG_OFFS    12
`define MMU_PTE_BYTES  8

// ----------------------------------------------------------------------
// page table entry layout
// ----------------------------------------------------------------------
`define MMU_PTE_V        0
`define MMU_PTE_R        1
`define MMU_PTE_W        2
`define MMU_PTE_X        3
`define MMU_PTE_U        4
// bit 5 is the global bit, not used without ASIDs
`define MMU_PTE_A        6
`define MMU_PTE_D        7
`define MMU_PTE_PPN_LSB  10

// ----------------------------------------------------------------------
// exception causes
// ----------------------------------------------------------------------
`define MMU_LD_ACCESS_FAULT  4'd5
`define MMU_ST_ACCESS_FAULT  4'd7
`define MMU_LD_PAGE_FAULT    4'd13
`define MMU_ST_PAGE_FAULT    4'd15

// privilege levels seen by loads and stores
`define MMU_PRIV_U  2'd0
`define MMU_PRIV_S  2'd1

// default number of TLB entries
`define MMU_DTLB_ENTRIES  4

// AXI read response
`define MMU_AXI_OKAY  2'b00

`endif

// File: common/mmu_pkg.sv
// Sv39 data MMU types
// vector types for addresses, PTEs and codes, plus the walker states
`default_nettype none

`include "mmu_defines.svh"

package mmu_pkg;

    typedef logic [`MMU_VLEN-1:0]    vaddr_t;
    typedef logic [`MMU_PLEN-1:0]    paddr_t;
    typedef logic [`MMU_PPN_W-1:0]   ppn_t;
    // three concatenated VPN fields, 1G field on top
    typedef logic [3*`MMU_VPN_W-1:0] vpn_t;
    typedef logic [`MMU_XLEN-1:0]    pte_t;
    typedef logic [`MMU_XLEN-1:0]    xlen_t;
    typedef logic [3:0]              cause_t;
    typedef logic [1:0]              priv_lvl_t;
    // page size: 0 = 4K, 1 = 2M, 2 = 1G
    typedef logic [1:0]              pg_level_t;

    // walker FSM
    typedef enum logic [1:0] {
        IDLE,
        SEND_AR,
        WAIT_R,
        FAULT
    } ptw_state_e;

endpackage

`default_nettype wire

// File: common/pt_mem_if.sv
// AXI4-Lite read channels of the page table walker
`default_nettype none

interface pt_mem_if;

    // read address channel
    logic            ar_valid;
    logic            ar_ready;
    mmu_pkg::paddr_t ar_addr;
    // read data channel
    logic            r_valid;
    logic            r_ready;
    mmu_pkg::xlen_t  r_data;
    logic [1:0]      r_resp;

    // walker side
    modport master (
        output ar_valid, ar_addr, r_ready,
        input  ar_ready, r_valid, r_data, r_resp
    );

    // memory side
    modport slave (
        input  ar_valid, ar_addr, r_ready,
        output ar_ready, r_valid, r_data, r_resp
    );

endinterface

`default_nettype wire

// File: common/tlb_update_if.sv
// TLB refill path from the walker into the data TLB
`default_nettype none

interface tlb_update_if;

    // single-cycle write pulse, the TLB always accepts it
    logic                 upd_valid;
    mmu_pkg::vpn_t        upd_vpn;
    mmu_pkg::pg_level_t   upd_level;
    mmu_pkg::pte_t        upd_pte;

    modport source (
        output upd_valid, upd_vpn, upd_level, upd_pte
    );

    modport sink (
        input  upd_valid, upd_vpn, upd_level, upd_pte
    );

endinterface

`default_nettype wire

// File: hw/dtlb/dtlb.sv
// fully associative data TLB
// 4K, 2M and 1G entries, combinational lookup, round-robin refill
`default_nettype none

`include "mmu_defines.svh"

module dtlb #(
    parameter int unsigned ENTRIES = `MMU_DTLB_ENTRIES
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  mmu_pkg::vaddr_t     lu_vaddr_i,
    tlb_update_if.sink          upd,
    output logic                lu_hit_o,
    output mmu_pkg::pte_t       lu_pte_o,
    output mmu_pkg::pg_level_t  lu_level_o
);

    localparam int unsigned IDX_W = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;
    localparam int unsigned VW    = `MMU_VPN_W;

    logic [ENTRIES-1:0] valid_q;
    logic [ENTRIES-1:0] match;
    mmu_pkg::vpn_t      vpn_q   [ENTRIES];
    mmu_pkg::pg_level_t level_q [ENTRIES];
    mmu_pkg::pte_t      pte_q   [ENTRIES];
    mmu_pkg::vpn_t      lu_vpn;
    logic [IDX_W-1:0]   rr_q;
    logic [IDX_W-1:0]   victim;
    logic               free_found;

    assign lu_vpn = lu_vaddr_i[`MMU_VLEN-1:`MMU_PG_OFFS];

    // ----------------------------------------------------------------------
    // lookup
    // ----------------------------------------------------------------------
    always_comb begin
        lu_hit_o   = 1'b0;
        lu_pte_o   = '0;
        lu_level_o = '0;
        for (int unsigned i = 0; i < ENTRIES; i++) begin
            // 1G field always, middle field below 1G, low field for 4K only
            match[i] = valid_q[i]
                && (vpn_q[i][2*VW +: VW] == lu_vpn[2*VW +: VW])
                && (level_q[i] == 2'd2 || vpn_q[i][VW +: VW] == lu_vpn[VW +: VW])
                && (level_q[i] != 2'd0 || vpn_q[i][0 +: VW] == lu_vpn[0 +: VW]);
            if (match[i]) begin
                lu_hit_o   = 1'b1;
                lu_pte_o   = pte_q[i];
                lu_level_o = level_q[i];
            end
        end
    end

    // refill slot: lowest free entry, else the round-robin pointer
    always_comb begin
        victim     = rr_q;
        free_found = 1'b0;
        for (int unsigned i = 0; i < ENTRIES; i++) begin
            if (!valid_q[i] && !free_found) begin
                victim     = IDX_W'(i);
                free_found = 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // entry state
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            rr_q    <= '0;
        end else if (flush_i) begin
            // flush wins over a refill in the same cycle
            valid_q <= '0;
        end else if (upd.upd_valid) begin
            valid_q[victim] <= 1'b1;
            if (!free_found) begin
                rr_q <= (rr_q == IDX_W'(ENTRIES - 1)) ? '0 : rr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (upd.upd_valid && !flush_i) begin
            vpn_q[victim]   <= upd.upd_vpn;
            level_q[victim] <= upd.upd_level;
            pte_q[victim]   <= upd.upd_pte;
        end
    end

    // walker only refills on a miss, so entries never overlap
    a_single_match: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(match))
        else $error("dtlb: more than one entry matches");

endmodule

`default_nettype wire

// File: hw/mmu_top.sv
// Sv39 data MMU top level
// data TLB, page table walker and load/store translation stage
`default_nettype none

`include "mmu_defines.svh"

module mmu_top (
    input  logic                clk_i,
    input  logic                rst_ni,
    // CSR state
    input  logic                enable_translation_i,
    input  mmu_pkg::priv_lvl_t  priv_lvl_i,
    input  logic                sum_i,
    input  mmu_pkg::ppn_t       satp_ppn_i,
    input  logic                flush_tlb_i,
    // load/store unit
    input  logic                lsu_req_i,
    input  mmu_pkg::vaddr_t     lsu_vaddr_i,
    input  logic                lsu_is_store_i,
    output logic                lsu_dtlb_hit_o,
    output logic                lsu_valid_o,
    output mmu_pkg::paddr_t     lsu_paddr_o,
    output logic                lsu_ex_valid_o,
    output mmu_pkg::cause_t     lsu_ex_cause_o,
    output mmu_pkg::xlen_t      lsu_ex_tval_o,
    // page table memory, AXI4-Lite read only
    output logic                mem_ar_valid_o,
    input  logic                mem_ar_ready_i,
    output mmu_pkg::paddr_t     mem_ar_addr_o,
    input  logic                mem_r_valid_i,
    output logic                mem_r_ready_o,
    input  mmu_pkg::xlen_t      mem_r_data_i,
    input  logic [1:0]          mem_r_resp_i
);

    // TLB lookup result, shared by walker and translation stage
    logic               dtlb_hit;
    mmu_pkg::pte_t      dtlb_pte;
    mmu_pkg::pg_level_t dtlb_level;
    // walker status
    logic               ptw_active;
    logic               ptw_error;
    logic               ptw_access_err;
    mmu_pkg::xlen_t     ptw_err_tval;

    pt_mem_if     mem_bus ();
    tlb_update_if upd_bus ();

    // memory port onto the pins
    assign mem_ar_valid_o   = mem_bus.ar_valid;
    assign mem_ar_addr_o    = mem_bus.ar_addr;
    assign mem_r_ready_o    = mem_bus.r_ready;
    assign mem_bus.ar_ready = mem_ar_ready_i;
    assign mem_bus.r_valid  = mem_r_valid_i;
    assign mem_bus.r_data   = mem_r_data_i;
    assign mem_bus.r_resp   = mem_r_resp_i;

    dtlb #(
        .ENTRIES    ( `MMU_DTLB_ENTRIES )
    ) i_dtlb (
        .clk_i      ( clk_i       ),
        .rst_ni     ( rst_ni      ),
        .flush_i    ( flush_tlb_i ),
        .lu_vaddr_i ( lsu_vaddr_i ),
        .upd        ( upd_bus     ),
        .lu_hit_o   ( dtlb_hit    ),
        .lu_pte_o   ( dtlb_pte    ),
        .lu_level_o ( dtlb_level  )
    );

    ptw i_ptw (
        .clk_i                ( clk_i                ),
        .rst_ni               ( rst_ni               ),
        .enable_translation_i ( enable_translation_i ),
        .satp_ppn_i           ( satp_ppn_i           ),
        .lsu_req_i            ( lsu_req_i            ),
        .lsu_vaddr_i          ( lsu_vaddr_i          ),
        .dtlb_hit_i           ( dtlb_hit             ),
        .ptw_active_o         ( ptw_active           ),
        .ptw_error_o          ( ptw_error            ),
        .ptw_access_err_o     ( ptw_access_err       ),
        .ptw_err_tval_o       ( ptw_err_tval         ),
        .mem                  ( mem_bus              ),
        .upd                  ( upd_bus              )
    );

    xlate_stage i_xlate_stage (
        .clk_i                ( clk_i                ),
        .rst_ni               ( rst_ni               ),
        .enable_translation_i ( enable_translation_i ),
        .priv_lvl_i           ( priv_lvl_i           ),
        .sum_i                ( sum_i                ),
        .lsu_req_i            ( lsu_req_i            ),
        .lsu_vaddr_i          ( lsu_vaddr_i          ),
        .lsu_is_store_i       ( lsu_is_store_i       ),
        .dtlb_hit_i           ( dtlb_hit             ),
        .dtlb_pte_i           ( dtlb_pte             ),
        .dtlb_level_i         ( dtlb_level           ),
        .ptw_active_i         ( ptw_active           ),
        .ptw_error_i          ( ptw_error            ),
        .ptw_access_err_i     ( ptw_access_err       ),
        .ptw_err_tval_i       ( ptw_err_tval         ),
        .lsu_dtlb_hit_o       ( lsu_dtlb_hit_o       ),
        .lsu_valid_o          ( lsu_valid_o          ),
        .lsu_paddr_o          ( lsu_paddr_o          ),
        .lsu_ex_valid_o       ( lsu_ex_valid_o       ),
        .lsu_ex_cause_o       ( lsu_ex_cause_o       ),
        .lsu_ex_tval_o        ( lsu_ex_tval_o        )
    );

endmodule

`default_nettype wire

// File: hw/ptw/ptw.sv
// Sv39 page table walker
// walks up to three levels over AXI4-Lite reads and refills the data TLB
`default_nettype none

`include "mmu_defines.svh"

module ptw (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                enable_translation_i,
    input  mmu_pkg::ppn_t       satp_ppn_i,
    input  logic                lsu_req_i,
    input  mmu_pkg::vaddr_t     lsu_vaddr_i,
    input  logic                dtlb_hit_i,
    output logic                ptw_active_o,
    output logic                ptw_error_o,
    output logic                ptw_access_err_o,
    output mmu_pkg::xlen_t      ptw_err_tval_o,
    pt_mem_if.master            mem,
    tlb_update_if.source        upd
);

    localparam int unsigned VW = `MMU_VPN_W;

    mmu_pkg::ptw_state_e state_q, state_d;
    mmu_pkg::vaddr_t     vaddr_q, vaddr_d;
    mmu_pkg::pg_level_t  level_q, level_d;
    mmu_pkg::ppn_t       base_q, base_d;
    logic                acc_err_q, acc_err_d;
    mmu_pkg::xlen_t      tval_q, tval_d;
    mmu_pkg::pte_t       pte;
    mmu_pkg::ppn_t       pte_ppn;
    logic [VW-1:0]       vpn_field;
    logic                is_leaf;
    logic                misaligned;

    assign pte     = mem.r_data;
    assign pte_ppn = pte[`MMU_PTE_PPN_LSB +: `MMU_PPN_W];
    assign is_leaf = pte[`MMU_PTE_R] | pte[`MMU_PTE_X];
    // superpage leaf must have its low PPN fields clear
    assign misaligned = (level_q == 2'd2 && |pte_ppn[2*VW-1:0])
                     || (level_q == 2'd1 && |pte_ppn[VW-1:0]);

    // PTE address: base page plus VPN field times PTE size
    assign vpn_field   = vaddr_q[`MMU_PG_OFFS + VW*level_q +: VW];
    assign mem.ar_addr = {base_q, {`MMU_PG_OFFS{1'b0}}}
                       + mmu_pkg::paddr_t'(vpn_field) * `MMU_PTE_BYTES;
    assign mem.ar_valid = (state_q == mmu_pkg::SEND_AR);
    assign mem.r_ready  = (state_q == mmu_pkg::WAIT_R);

    // refill fields, the pulse comes from the FSM
    assign upd.upd_vpn   = vaddr_q[`MMU_VLEN-1:`MMU_PG_OFFS];
    assign upd.upd_level = level_q;
    assign upd.upd_pte   = pte;

    assign ptw_active_o     = (state_q != mmu_pkg::IDLE);
    assign ptw_error_o      = (state_q == mmu_pkg::FAULT) && !acc_err_q;
    assign ptw_access_err_o = (state_q == mmu_pkg::FAULT) && acc_err_q;
    assign ptw_err_tval_o   = tval_q;

    // ----------------------------------------------------------------------
    // walk FSM
    // ----------------------------------------------------------------------
    always_comb begin
        state_d       = state_q;
        vaddr_d       = vaddr_q;
        level_d       = level_q;
        base_d        = base_q;
        acc_err_d     = acc_err_q;
        tval_d        = tval_q;
        upd.upd_valid = 1'b0;
        case (state_q)
            mmu_pkg::IDLE: begin
                // start at the 1G level from satp
                if (enable_translation_i && lsu_req_i && !dtlb_hit_i) begin
                    vaddr_d = lsu_vaddr_i;
                    level_d = 2'd2;
                    base_d  = satp_ppn_i;
                    state_d = mmu_pkg::SEND_AR;
                end
            end
            mmu_pkg::SEND_AR: begin
                if (mem.ar_ready) begin
                    state_d = mmu_pkg::WAIT_R;
                end
            end
            mmu_pkg::WAIT_R: begin
                if (mem.r_valid) begin
                    // assume a page fault, the good cases override
                    state_d   = mmu_pkg::FAULT;
                    acc_err_d = 1'b0;
                    tval_d    = {{(`MMU_XLEN-`MMU_VLEN){vaddr_q[`MMU_VLEN-1]}}, vaddr_q};
                    if (mem.r_resp != `MMU_AXI_OKAY) begin
                        acc_err_d = 1'b1;
                        tval_d    = mmu_pkg::xlen_t'(mem.ar_addr);
                    end else if (!pte[`MMU_PTE_V] || (pte[`MMU_PTE_W] && !pte[`MMU_PTE_R])) begin
                        state_d = mmu_pkg::FAULT;
                    end else if (is_leaf) begin
                        if (pte[`MMU_PTE_A] && !misaligned) begin
                            upd.upd_valid = 1'b1;
                            state_d       = mmu_pkg::IDLE;
                        end
                    end else if (level_q != 2'd0) begin
                        // pointer to the next level
                        base_d  = pte_ppn;
                        level_d = level_q - 2'd1;
                        state_d = mmu_pkg::SEND_AR;
                    end
                end
            end
            default: begin
                // FAULT is reported for one cycle
                state_d = mmu_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= mmu_pkg::IDLE;
            acc_err_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            acc_err_q <= acc_err_d;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q <= vaddr_d;
        level_q <= level_d;
        base_q  <= base_d;
        tval_q  <= tval_d;
    end

    // AXI rule, address held until accepted
    a_ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem.ar_valid && !mem.ar_ready |=> mem.ar_valid && $stable(mem.ar_addr))
        else $error("ptw: AR changed while stalled");

endmodule

`default_nettype wire

// File: hw/xlate_stage.sv
// load/store address translation stage
// registers the request with the TLB result, checks permissions, picks the exception
`default_nettype none

`include "mmu_defines.svh"

module xlate_stage (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                enable_translation_i,
    input  mmu_pkg::priv_lvl_t  priv_lvl_i,
    input  logic                sum_i,
    input  logic                lsu_req_i,
    input  mmu_pkg::vaddr_t     lsu_vaddr_i,
    input  logic                lsu_is_store_i,
    input  logic                dtlb_hit_i,
    input  mmu_pkg::pte_t       dtlb_pte_i,
    input  mmu_pkg::pg_level_t  dtlb_level_i,
    input  logic                ptw_active_i,
    input  logic                ptw_error_i,
    input  logic                ptw_access_err_i,
    input  mmu_pkg::xlen_t      ptw_err_tval_i,
    output logic                lsu_dtlb_hit_o,
    output logic                lsu_valid_o,
    output mmu_pkg::paddr_t     lsu_paddr_o,
    output logic                lsu_ex_valid_o,
    output mmu_pkg::cause_t     lsu_ex_cause_o,
    output mmu_pkg::xlen_t      lsu_ex_tval_o
);

    localparam int unsigned VW = `MMU_VPN_W;
    localparam int unsigned PO = `MMU_PG_OFFS;

    logic               req_q, hit_q, store_q, en_q, sum_q;
    mmu_pkg::vaddr_t    vaddr_q;
    mmu_pkg::pte_t      pte_q;
    mmu_pkg::pg_level_t level_q;
    mmu_pkg::priv_lvl_t priv_q;
    mmu_pkg::xlen_t     vaddr_sext;
    logic               priv_err;

    // with translation off every request hits
    assign lsu_dtlb_hit_o = enable_translation_i ? dtlb_hit_i : 1'b1;

    assign vaddr_sext = {{(`MMU_XLEN-`MMU_VLEN){vaddr_q[`MMU_VLEN-1]}}, vaddr_q};
    // U page from S mode needs SUM, U mode needs a U page
    assign priv_err = (priv_q == `MMU_PRIV_S && !sum_q && pte_q[`MMU_PTE_U])
                   || (priv_q == `MMU_PRIV_U && !pte_q[`MMU_PTE_U]);

    always_comb begin
        lsu_valid_o    = req_q;
        lsu_paddr_o    = mmu_pkg::paddr_t'(vaddr_q);
        lsu_ex_valid_o = 1'b0;
        lsu_ex_cause_o = '0;
        lsu_ex_tval_o  = '0;
        if (en_q) begin
            lsu_valid_o = 1'b0;
            lsu_paddr_o = {pte_q[`MMU_PTE_PPN_LSB +: `MMU_PPN_W], vaddr_q[PO-1:0]};
            // superpages take the low PPN fields from the vaddr
            if (level_q == 2'd1) begin
                lsu_paddr_o[PO +: VW] = vaddr_q[PO +: VW];
            end
            if (level_q == 2'd2) begin
                lsu_paddr_o[PO +: 2*VW] = vaddr_q[PO +: 2*VW];
            end
            if (req_q && hit_q) begin
                lsu_valid_o = 1'b1;
                if (store_q && (!pte_q[`MMU_PTE_W] || !pte_q[`MMU_PTE_D] || priv_err)) begin
                    lsu_ex_valid_o = 1'b1;
                    lsu_ex_cause_o = `MMU_ST_PAGE_FAULT;
                    lsu_ex_tval_o  = vaddr_sext;
                end else if (!store_q && priv_err) begin
                    lsu_ex_valid_o = 1'b1;
                    lsu_ex_cause_o = `MMU_LD_PAGE_FAULT;
                    lsu_ex_tval_o  = vaddr_sext;
                end
            end else if (req_q && ptw_active_i && (ptw_error_i || ptw_access_err_i)) begin
                // failed walk completes the held request
                lsu_valid_o    = 1'b1;
                lsu_ex_valid_o = 1'b1;
                lsu_ex_tval_o  = ptw_err_tval_i;
                if (ptw_access_err_i) begin
                    lsu_ex_cause_o = store_q ? `MMU_ST_ACCESS_FAULT : `MMU_LD_ACCESS_FAULT;
                end else begin
                    lsu_ex_cause_o = store_q ? `MMU_ST_PAGE_FAULT : `MMU_LD_PAGE_FAULT;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // request register
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_q <= 1'b0;
            hit_q <= 1'b0;
        end else begin
            req_q <= lsu_req_i;
            hit_q <= dtlb_hit_i;
        end
    end

    always_ff @(posedge clk_i) begin
        vaddr_q <= lsu_vaddr_i;
        store_q <= lsu_is_store_i;
        pte_q   <= dtlb_pte_i;
        level_q <= dtlb_level_i;
        en_q    <= enable_translation_i;
        priv_q  <= priv_lvl_i;
        sum_q   <= sum_i;
    end

    a_ex_has_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_ex_valid_o |-> lsu_valid_o)
        else $error("xlate_stage: exception without valid");

endmodule

`default_nettype wire

// File: mmu_top.f
+incdir+common
common/mmu_pkg.sv
common/pt_mem_if.sv
common/tlb_update_if.sv
hw/dtlb/dtlb.sv
hw/ptw/ptw.sv
hw/xlate_stage.sv
hw/mmu_top.sv
tb/tb_mmu_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the MMU testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_mmu_top -f mmu_top.f -o sim_mmu_top
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_mmu_top > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
exit 0

// File: tb/tb_mmu_top.sv
// testbench for the Sv39 data MMU
// page table memory model with random AXI stalls, stimulus table and checks
`default_nettype none

module tb_mmu_top;

    // ----------------------------------------------------------------------
    // run length
    // ----------------------------------------------------------------------
    // per row up to three walk reads of about 8 cycles plus request and gap cycles
    localparam int READ_CYCLES = 8;
    localparam int ROW_EXTRA   = 4;

    // one row of stimulus and expected response
    typedef struct packed {
        logic        en;
        logic [1:0]  priv;
        logic        sum;
        logic        store;
        logic        flush;
        logic [38:0] vaddr;
        logic        hit;
        logic [55:0] paddr;
        logic        ex;
        logic [3:0]  cause;
        logic [63:0] tval;
        logic [3:0]  reads;
    } row_t;

    logic        clk_i;
    logic        rst_ni;
    logic        enable_translation_i;
    logic [1:0]  priv_lvl_i;
    logic        sum_i;
    logic [43:0] satp_ppn_i;
    logic        flush_tlb_i;
    logic        lsu_req_i;
    logic [38:0] lsu_vaddr_i;
    logic        lsu_is_store_i;
    logic        lsu_dtlb_hit_o;
    logic        lsu_valid_o;
    logic [55:0] lsu_paddr_o;
    logic        lsu_ex_valid_o;
    logic [3:0]  lsu_ex_cause_o;
    logic [63:0] lsu_ex_tval_o;
    logic        mem_ar_valid_o;
    logic        mem_ar_ready_i;
    logic [55:0] mem_ar_addr_o;
    logic        mem_r_valid_i;
    logic        mem_r_ready_o;
    logic [63:0] mem_r_data_i;
    logic [1:0]  mem_r_resp_i;

    row_t        rows[$];
    logic [63:0] page_mem[logic [55:0]];
    logic [31:0] lfsr;
    logic [2:0]  mem_state;
    logic [1:0]  wait_cnt;
    logic [55:0] rd_addr;
    int          read_count;
    int          cycle_cnt;
    int          limit;
    int          errors;

    mmu_top i_mmu_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run("value mismatch");
        end
    endtask

    // one galois LFSR step
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_delay(output logic [1:0] d);
        for (int i = 0; i < 2; i++) begin
            d[i] = lfsr[0];
            lfsr = lfsr_step(lfsr);
        end
    endtask

    // raw PTE from page number and flag bits
    function automatic logic [63:0] make_pte(input logic [43:0] ppn, input logic [9:0] flags);
        return {10'b0, ppn, flags};
    endfunction

    function automatic logic [63:0] pte_at(input logic [55:0] addr);
        return page_mem.exists(addr) ? page_mem[addr] : 64'h0;
    endfunction

    task automatic add_row(input logic en, input logic [1:0] priv, input logic sum,
                           input logic store, input logic flush, input logic [38:0] va,
                           input logic hit, input logic [55:0] pa, input logic ex,
                           input logic [3:0] cause, input logic [63:0] tval,
                           input logic [3:0] reads);
        row_t r;
        r = '{en, priv, sum, store, flush, va, hit, pa, ex, cause, tval, reads};
        rows.push_back(r);
    endtask

    // ----------------------------------------------------------------------
    // page table memory as an AXI4-Lite read slave
    // ----------------------------------------------------------------------
    always @(posedge clk_i or negedge rst_ni) begin
        logic [1:0] d;
        if (!rst_ni) begin
            mem_ar_ready_i <= 1'b0;
            mem_r_valid_i  <= 1'b0;
            mem_r_data_i   <= '0;
            mem_r_resp_i   <= 2'b00;
            mem_state      <= 3'd0;
            wait_cnt       <= 2'd0;
        end else begin
            case (mem_state)
                3'd0: if (mem_ar_valid_o) begin
                    random_delay(d);
                    wait_cnt  <= d;
                    mem_state <= 3'd1;
                end
                3'd1: if (wait_cnt == 2'd0) begin
                    mem_ar_ready_i <= 1'b1;
                    mem_state      <= 3'd2;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
                3'd2: begin
                    // AR handshake at this edge
                    mem_ar_ready_i <= 1'b0;
                    rd_addr        <= mem_ar_addr_o;
                    read_count     <= read_count + 1;
                    random_delay(d);
                    wait_cnt  <= d;
                    mem_state <= 3'd3;
                end
                3'd3: if (wait_cnt == 2'd0) begin
                    mem_r_valid_i <= 1'b1;
                    mem_r_data_i  <= pte_at(rd_addr);
                    // page 0x103 is a slave error region
                    mem_r_resp_i  <= (rd_addr[55:12] == 44'h103) ? 2'b10 : 2'b00;
                    mem_state     <= 3'd4;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
                default: if (mem_r_ready_o) begin
                    mem_r_valid_i <= 1'b0;
                    mem_state     <= 3'd0;
                end
            endcase
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= limit) begin
            abort_run("timeout: the DUT did not finish the test rows in time");
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    initial begin
        int n;
        logic first_hit;
        row_t r;
        lfsr = 32'd73965;
        cycle_cnt = 0;
        read_count = 0;
        errors = 0;
        rst_ni = 1'b0;
        enable_translation_i = 1'b0;
        priv_lvl_i = 2'd1;
        sum_i = 1'b0;
        satp_ppn_i = 44'h100;
        flush_tlb_i = 1'b0;
        lsu_req_i = 1'b0;
        lsu_vaddr_i = '0;
        lsu_is_store_i = 1'b0;
        mem_ar_ready_i = 1'b0;
        mem_r_valid_i = 1'b0;
        mem_r_data_i = '0;
        mem_r_resp_i = 2'b00;

        // root table at 0x100000 with next levels at 0x101000 and 0x102000
        page_mem[56'h100000] = make_pte(44'h101, 10'h001);
        // 1G leaf
        page_mem[56'h100008] = make_pte(44'hC0000, 10'h0C7);
        // pointer into the error region
        page_mem[56'h100010] = make_pte(44'h103, 10'h001);
        page_mem[56'h101000] = make_pte(44'h102, 10'h001);
        // 2M leaf
        page_mem[56'h101008] = make_pte(44'h400, 10'h0C7);
        page_mem[56'h102000] = make_pte(44'h5000, 10'h0C7);
        // read-only page
        page_mem[56'h102008] = make_pte(44'h5001, 10'h0C3);
        // writable page with D clear
        page_mem[56'h102010] = make_pte(44'h5002, 10'h047);
        // user page
        page_mem[56'h102018] = make_pte(44'h5003, 10'h0D7);

        //      en priv  sum st fl vaddr             hit paddr          ex cause tval reads
        add_row(0, 2'd1, 0, 0, 0, 39'h12_3456_789, 1, 56'h12_3456_789, 0, 0, 0, 0);
        add_row(1, 2'd1, 0, 0, 0, 39'h123, 0, 56'h500_0123, 0, 0, 0, 3);
        add_row(1, 2'd1, 0, 0, 0, 39'h123, 1, 56'h500_0123, 0, 0, 0, 0);
        add_row(1, 2'd1, 0, 0, 0, 39'h24_5678, 0, 56'h44_5678, 0, 0, 0, 2);
        add_row(1, 2'd1, 0, 0, 0, 39'h4243_4abc, 0, 56'hC243_4abc, 0, 0, 0, 1);
        add_row(1, 2'd1, 0, 1, 0, 39'h1010, 0, 0, 1, 4'd15, 64'h1010, 3);
        add_row(1, 2'd1, 0, 1, 0, 39'h2020, 0, 0, 1, 4'd15, 64'h2020, 3);
        add_row(1, 2'd0, 0, 0, 0, 39'h24_5678, 1, 0, 1, 4'd13, 64'h24_5678, 0);
        add_row(1, 2'd1, 0, 0, 0, 39'h3030, 0, 0, 1, 4'd13, 64'h3030, 3);
        add_row(1, 2'd1, 1, 0, 0, 39'h3030, 1, 56'h500_3030, 0, 0, 0, 0);
        add_row(1, 2'd1, 0, 0, 0, 39'h40_0000_0111, 0, 0, 1, 4'd13,
                64'hFFFF_FFC0_0000_0111, 1);
        add_row(1, 2'd1, 0, 0, 0, 39'h80E0_0044, 0, 0, 1, 4'd5, 64'h10_3038, 2);
        add_row(1, 2'd1, 0, 1, 0, 39'h80E0_0044, 0, 0, 1, 4'd7, 64'h10_3038, 2);
        add_row(1, 2'd1, 1, 0, 1, 39'h3030, 0, 56'h500_3030, 0, 0, 0, 3);
        add_row(1, 2'd1, 0, 1, 0, 39'h24_5678, 0, 56'h44_5678, 0, 0, 0, 2);

        limit = rows.size() * (3 * READ_CYCLES + ROW_EXTRA);

        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;
        repeat (2) @(posedge clk_i);

        foreach (rows[i]) begin
            r = rows[i];
            if (r.flush) begin
                flush_tlb_i <= 1'b1;
                @(posedge clk_i);
                flush_tlb_i <= 1'b0;
            end
            enable_translation_i <= r.en;
            priv_lvl_i           <= r.priv;
            sum_i                <= r.sum;
            lsu_is_store_i       <= r.store;
            lsu_vaddr_i          <= r.vaddr;
            lsu_req_i            <= 1'b1;
            read_count = 0;
            // hit is combinational in the request cycle
            @(negedge clk_i);
            first_hit = lsu_dtlb_hit_o;
            check_value("lsu_dtlb_hit_o", 64'(first_hit), 64'(r.hit));
            n = 0;
            do begin
                @(negedge clk_i);
                n++;
            end while (!lsu_valid_o);
            if (r.hit) begin
                check_value("valid latency", 64'(n), 64'd1);
            end
            check_value("lsu_ex_valid_o", 64'(lsu_ex_valid_o), 64'(r.ex));
            if (r.ex) begin
                check_value("lsu_ex_cause_o", 64'(lsu_ex_cause_o), 64'(r.cause));
                check_value("lsu_ex_tval_o", lsu_ex_tval_o, r.tval);
            end else begin
                check_value("lsu_paddr_o", 64'(lsu_paddr_o), 64'(r.paddr));
            end
            check_value("read count", 64'(read_count), 64'(r.reads));
            @(posedge clk_i);
            lsu_req_i <= 1'b0;
            repeat (3) @(posedge clk_i);
        end

        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
